// ==== design/bridge_map_pkg.sv ====
// bridge map definitions
// bus word type, register addresses and register reset values
// for the host bridge of the test pattern core

package bridge_map_pkg;

	// one bridge address or data word
	typedef logic [31:0] bus_word_t;

	//////////////////////////////////////////////////
	// address map
	//////////////////////////////////////////////////

	// square position, read and write
	localparam bus_word_t ADDR_SQUARE_X    = 32'h0020_0000;
	localparam bus_word_t ADDR_SQUARE_Y    = 32'h0020_0004;
	// plain control registers
	localparam bus_word_t ADDR_ANIM_EN     = 32'h0010_0000;
	localparam bus_word_t ADDR_DEBUG       = 32'h0010_0004;
	localparam bus_word_t ADDR_SCRATCH     = 32'h0030_0000;
	localparam bus_word_t ADDR_CHAN_EN     = 32'h00F0_000C;
	// write-only strobes, data is ignored
	localparam bus_word_t ADDR_SQUARE_RST  = 32'h00F0_0010;
	localparam bus_word_t ADDR_FRAME_RST   = 32'h00F0_0014;
	localparam bus_word_t ADDR_FRAME_INCR  = 32'h00F0_0018;
	// read-only status
	localparam bus_word_t ADDR_FRAME_COUNT = 32'h2000_0000;

	// reset values
	localparam bus_word_t  DEBUG_RESET   = 32'h1200_5678;
	localparam logic [2:0] CHAN_EN_RESET = 3'b111;
	localparam logic       ANIM_EN_RESET = 1'b1;

endpackage

// ==== design/video_pkg.sv ====
// video definitions
// raster and pixel types, controller key bits and the colour constants

package video_pkg;

	// raster counters and square position
	typedef logic [9:0]  coord_t;
	typedef logic [15:0] frame_count_t;
	// channel enables, red in the top bit
	typedef logic [2:0]  chan_mask_t;
	// 8 bits per channel, red in the top byte
	typedef logic [23:0] rgb_t;
	// controller key bitmap
	typedef logic [15:0] cont_key_t;

	// key bit positions
	localparam int KEY_UP     = 0;
	localparam int KEY_DOWN   = 1;
	localparam int KEY_LEFT   = 2;
	localparam int KEY_RIGHT  = 3;
	localparam int KEY_FACE_A = 4;
	localparam int KEY_FACE_B = 5;

	//////////////////////////////////////////////////
	// colours
	//////////////////////////////////////////////////

	localparam rgb_t COLOR_WHITE   = 24'hFF_FF_FF;
	localparam rgb_t COLOR_GREEN   = 24'h00_FF_00;
	localparam rgb_t COLOR_RED     = 24'hFF_00_00;
	localparam rgb_t COLOR_BLUE    = 24'h00_00_FF;
	localparam rgb_t COLOR_MAGENTA = 24'hFF_00_FF;
	localparam rgb_t COLOR_BLACK   = 24'h00_00_00;

endpackage

// ==== design/bridge_regs.sv ====
// bridge register block
// decodes host bridge writes into control registers and one-cycle strobes,
// and muxes register and status values onto the read data

module bridge_regs (
	input  logic                      clk_74a,
	input  logic                      reset_n,
	input  bridge_map_pkg::bus_word_t bridge_addr,
	input  logic                      bridge_wr,
	input  bridge_map_pkg::bus_word_t bridge_wr_data,
	input  logic                      bridge_rd,
	output bridge_map_pkg::bus_word_t bridge_rd_data,
	input  video_pkg::coord_t         square_x,
	input  video_pkg::coord_t         square_y,
	input  video_pkg::frame_count_t   frame_count,
	output video_pkg::chan_mask_t     chan_en,
	output logic                      anim_en,
	output logic                      frame_rst,
	output logic                      frame_incr,
	output logic                      square_rst,
	output logic                      square_load_x,
	output logic                      square_load_y,
	output video_pkg::coord_t         square_new
);

	import bridge_map_pkg::*;

	// host-only registers, not used by the video path
	bus_word_t debug_value;
	bus_word_t scratch_value;

	//////////////////////////////////////////////////
	// write decode
	//////////////////////////////////////////////////

	always_ff @(posedge clk_74a or negedge reset_n) begin
		if (!reset_n) begin
			chan_en       <= CHAN_EN_RESET;
			anim_en       <= ANIM_EN_RESET;
			debug_value   <= DEBUG_RESET;
			scratch_value <= '0;
			frame_rst     <= 1'b0;
			frame_incr    <= 1'b0;
			square_rst    <= 1'b0;
			square_load_x <= 1'b0;
			square_load_y <= 1'b0;
		end else begin
			// strobes last one cycle
			frame_rst     <= 1'b0;
			frame_incr    <= 1'b0;
			square_rst    <= 1'b0;
			square_load_x <= 1'b0;
			square_load_y <= 1'b0;

			if (bridge_wr) begin
				case (bridge_addr)
					ADDR_SQUARE_X:   square_load_x <= 1'b1;
					ADDR_SQUARE_Y:   square_load_y <= 1'b1;
					ADDR_CHAN_EN:    chan_en       <= bridge_wr_data[2:0];
					ADDR_ANIM_EN:    anim_en       <= bridge_wr_data[0];
					ADDR_DEBUG:      debug_value   <= bridge_wr_data;
					ADDR_SCRATCH:    scratch_value <= bridge_wr_data;
					ADDR_SQUARE_RST: square_rst    <= 1'b1;
					ADDR_FRAME_RST:  frame_rst     <= 1'b1;
					ADDR_FRAME_INCR: frame_incr    <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	// new coordinate, valid while the load strobe is high
	always_ff @(posedge clk_74a) begin
		if (bridge_wr && (bridge_addr == ADDR_SQUARE_X || bridge_addr == ADDR_SQUARE_Y)) begin
			square_new <= bridge_wr_data[9:0];
		end
	end

	//////////////////////////////////////////////////
	// read mux
	//////////////////////////////////////////////////

	// narrow values zero extended, unmapped reads 0
	always_comb begin
		bridge_rd_data = '0;
		if (bridge_rd) begin
			case (bridge_addr)
				ADDR_SQUARE_X:    bridge_rd_data = bus_word_t'(square_x);
				ADDR_SQUARE_Y:    bridge_rd_data = bus_word_t'(square_y);
				ADDR_CHAN_EN:     bridge_rd_data = bus_word_t'(chan_en);
				ADDR_ANIM_EN:     bridge_rd_data = bus_word_t'(anim_en);
				ADDR_DEBUG:       bridge_rd_data = debug_value;
				ADDR_SCRATCH:     bridge_rd_data = scratch_value;
				ADDR_FRAME_COUNT: bridge_rd_data = bus_word_t'(frame_count);
				default:          bridge_rd_data = '0;
			endcase
		end
	end

endmodule

// ==== design/raster_timing.sv ====
// raster timing generator
// free-running horizontal and vertical counters, vertical and horizontal
// sync pulses and the frame counter

module raster_timing #(
	parameter int H_TOTAL = 400,
	parameter int V_TOTAL = 512
) (
	input  logic                    clk_74a,
	input  logic                    reset_n,
	input  logic                    anim_en,
	input  logic                    frame_rst,
	input  logic                    frame_incr,
	output video_pkg::coord_t       x_count,
	output video_pkg::coord_t       y_count,
	output logic                    frame_start,
	output logic                    video_vs,
	output logic                    video_hs,
	output video_pkg::frame_count_t frame_count
);

	import video_pkg::*;

	// last count before wrap
	localparam coord_t H_LAST = coord_t'(H_TOTAL - 1);
	localparam coord_t V_LAST = coord_t'(V_TOTAL - 1);

	// hs lands a few cycles after vs
	localparam coord_t HS_POS = coord_t'(3);

	logic at_origin;

	assign at_origin = (x_count == '0) && (y_count == '0);

	always_ff @(posedge clk_74a or negedge reset_n) begin
		if (!reset_n) begin
			x_count     <= '0;
			y_count     <= '0;
			frame_start <= 1'b0;
			video_hs    <= 1'b0;
			frame_count <= '0;
		end else begin
			// x wraps at end of line, y steps on each wrap
			if (x_count == H_LAST) begin
				x_count <= '0;
				if (y_count == V_LAST) begin
					y_count <= '0;
				end else begin
					y_count <= y_count + 1'b1;
				end
			end else begin
				x_count <= x_count + 1'b1;
			end

			// sync pulses, one cycle each
			frame_start <= at_origin;
			video_hs    <= (x_count == HS_POS);

			// frame counter, later rule wins
			if (at_origin && anim_en) begin
				frame_count <= frame_count + 1'b1;
			end
			if (frame_rst) begin
				frame_count <= '0;
			end
			if (frame_incr) begin
				frame_count <= frame_count + 1'b1;
			end
		end
	end

	// vs is the frame start pulse itself
	assign video_vs = frame_start;

endmodule

// ==== design/square_sprite.sv ====
// square sprite position
// moves one pixel per frame with the d-pad, clamped to the active area,
// and can be reset or loaded from the bridge

module square_sprite #(
	parameter int H_ACTIVE    = 320,
	parameter int V_ACTIVE    = 288,
	parameter int SQUARE_SIZE = 50
) (
	input  logic                 clk_74a,
	input  logic                 reset_n,
	input  logic                 frame_start,
	input  video_pkg::cont_key_t key,
	input  logic                 square_rst,
	input  logic                 square_load_x,
	input  logic                 square_load_y,
	input  video_pkg::coord_t    square_new,
	output video_pkg::coord_t    square_x,
	output video_pkg::coord_t    square_y
);

	import video_pkg::*;

	// centred start position
	localparam coord_t INIT_X = coord_t'(H_ACTIVE / 2 - SQUARE_SIZE / 2);
	localparam coord_t INIT_Y = coord_t'(V_ACTIVE / 2 - SQUARE_SIZE / 2);
	// highest position keeping the square on screen
	localparam coord_t MAX_X  = coord_t'(H_ACTIVE - SQUARE_SIZE);
	localparam coord_t MAX_Y  = coord_t'(V_ACTIVE - SQUARE_SIZE);

	always_ff @(posedge clk_74a or negedge reset_n) begin
		if (!reset_n) begin
			square_x <= INIT_X;
			square_y <= INIT_Y;
		end else begin
			// d-pad motion once per frame
			if (frame_start) begin
				if (key[KEY_UP] && square_y != '0) begin
					square_y <= square_y - 1'b1;
				end
				if (key[KEY_DOWN] && square_y < MAX_Y) begin
					square_y <= square_y + 1'b1;
				end
				if (key[KEY_LEFT] && square_x != '0) begin
					square_x <= square_x - 1'b1;
				end
				if (key[KEY_RIGHT] && square_x < MAX_X) begin
					square_x <= square_x + 1'b1;
				end
			end

			// bridge reset overrides motion
			if (square_rst) begin
				square_x <= INIT_X;
				square_y <= INIT_Y;
			end

			// loads win over everything, no clamping
			if (square_load_x) begin
				square_x <= square_new;
			end
			if (square_load_y) begin
				square_y <= square_new;
			end
		end
	end

endmodule

// ==== design/pixel_shader.sv ====
// pixel shader
// registered colour and data enable for the current raster position,
// with edge markers, the square and a black background

module pixel_shader #(
	parameter int H_BPORCH    = 10,
	parameter int H_ACTIVE    = 320,
	parameter int V_BPORCH    = 10,
	parameter int V_ACTIVE    = 288,
	parameter int SQUARE_SIZE = 50
) (
	input  logic                  clk_74a,
	input  logic                  reset_n,
	input  video_pkg::coord_t     x_count,
	input  video_pkg::coord_t     y_count,
	input  video_pkg::coord_t     square_x,
	input  video_pkg::coord_t     square_y,
	input  video_pkg::cont_key_t  key,
	input  video_pkg::chan_mask_t chan_en,
	output video_pkg::rgb_t       video_rgb,
	output logic                  video_de
);

	import video_pkg::*;

	// active window bounds, end exclusive
	localparam coord_t H_START = coord_t'(H_BPORCH);
	localparam coord_t H_END   = coord_t'(H_BPORCH + H_ACTIVE);
	localparam coord_t V_START = coord_t'(V_BPORCH);
	localparam coord_t V_END   = coord_t'(V_BPORCH + V_ACTIVE);
	localparam coord_t X_LAST  = coord_t'(H_ACTIVE - 1);
	localparam coord_t Y_LAST  = coord_t'(V_ACTIVE - 1);
	// one extra bit so a loaded square near the top of range does not wrap
	localparam logic [10:0] SIZE_EXT = 11'(SQUARE_SIZE);

	coord_t      visible_x;
	coord_t      visible_y;
	logic        active;
	logic [10:0] square_x_end;
	logic [10:0] square_y_end;
	logic        in_square;
	rgb_t        square_rgb;
	rgb_t        next_rgb;

	assign visible_x = x_count - H_START;
	assign visible_y = y_count - V_START;
	assign active    = (x_count >= H_START) && (x_count < H_END) &&
	                   (y_count >= V_START) && (y_count < V_END);

	assign square_x_end = {1'b0, square_x} + SIZE_EXT;
	assign square_y_end = {1'b0, square_y} + SIZE_EXT;
	assign in_square    = (visible_x >= square_x) && ({1'b0, visible_x} < square_x_end) &&
	                      (visible_y >= square_y) && ({1'b0, visible_y} < square_y_end);

	// square colour from face keys, then per-channel mask
	always_comb begin
		if (key[KEY_FACE_A]) begin
			square_rgb = COLOR_MAGENTA;
		end else if (key[KEY_FACE_B]) begin
			square_rgb = COLOR_GREEN;
		end else begin
			square_rgb = COLOR_WHITE;
		end
		square_rgb = square_rgb & {{8{chan_en[2]}}, {8{chan_en[1]}}, {8{chan_en[0]}}};
	end

	// edge markers first, then square, black elsewhere
	always_comb begin
		next_rgb = COLOR_BLACK;
		if (active) begin
			if (visible_x == '0) begin
				next_rgb = COLOR_WHITE;
			end else if (visible_x == X_LAST) begin
				next_rgb = COLOR_GREEN;
			end else if (visible_y == '0) begin
				next_rgb = COLOR_RED;
			end else if (visible_y == Y_LAST) begin
				next_rgb = COLOR_BLUE;
			end else if (in_square) begin
				next_rgb = square_rgb;
			end
		end
	end

	//////////////////////////////////////////////////
	// output register, one cycle behind the counters
	//////////////////////////////////////////////////

	always_ff @(posedge clk_74a or negedge reset_n) begin
		if (!reset_n) begin
			video_rgb <= COLOR_BLACK;
			video_de  <= 1'b0;
		end else begin
			video_rgb <= next_rgb;
			video_de  <= active;
		end
	end

endmodule

// ==== design/test_pattern_top.sv ====
// test pattern core top level
// bridge registers, raster timing, moving square and pixel shader on clk_74a

module test_pattern_top #(
	parameter int H_BPORCH    = 10,
	parameter int H_ACTIVE    = 320,
	parameter int H_TOTAL     = 400,
	parameter int V_BPORCH    = 10,
	parameter int V_ACTIVE    = 288,
	parameter int V_TOTAL     = 512,
	parameter int SQUARE_SIZE = 50
) (
	input  logic                      clk_74a,
	input  logic                      reset_n,
	input  bridge_map_pkg::bus_word_t bridge_addr,
	input  logic                      bridge_wr,
	input  bridge_map_pkg::bus_word_t bridge_wr_data,
	input  logic                      bridge_rd,
	output bridge_map_pkg::bus_word_t bridge_rd_data,
	input  video_pkg::cont_key_t      cont1_key,
	output video_pkg::rgb_t           video_rgb,
	output logic                      video_de,
	output logic                      video_vs,
	output logic                      video_hs
);

	import video_pkg::*;

	// control from the bridge
	chan_mask_t   chan_en;
	logic         anim_en;
	logic         frame_rst;
	logic         frame_incr;
	logic         square_rst;
	logic         square_load_x;
	logic         square_load_y;
	coord_t       square_new;
	// raster state
	coord_t       x_count;
	coord_t       y_count;
	logic         frame_start;
	frame_count_t frame_count;
	// sprite position
	coord_t       square_x;
	coord_t       square_y;

	bridge_regs regs_i (
		.clk_74a        (clk_74a),
		.reset_n        (reset_n),
		.bridge_addr    (bridge_addr),
		.bridge_wr      (bridge_wr),
		.bridge_wr_data (bridge_wr_data),
		.bridge_rd      (bridge_rd),
		.bridge_rd_data (bridge_rd_data),
		.square_x       (square_x),
		.square_y       (square_y),
		.frame_count    (frame_count),
		.chan_en        (chan_en),
		.anim_en        (anim_en),
		.frame_rst      (frame_rst),
		.frame_incr     (frame_incr),
		.square_rst     (square_rst),
		.square_load_x  (square_load_x),
		.square_load_y  (square_load_y),
		.square_new     (square_new)
	);

	raster_timing #(
		.H_TOTAL (H_TOTAL),
		.V_TOTAL (V_TOTAL)
	) raster_i (
		.clk_74a     (clk_74a),
		.reset_n     (reset_n),
		.anim_en     (anim_en),
		.frame_rst   (frame_rst),
		.frame_incr  (frame_incr),
		.x_count     (x_count),
		.y_count     (y_count),
		.frame_start (frame_start),
		.video_vs    (video_vs),
		.video_hs    (video_hs),
		.frame_count (frame_count)
	);

	square_sprite #(
		.H_ACTIVE    (H_ACTIVE),
		.V_ACTIVE    (V_ACTIVE),
		.SQUARE_SIZE (SQUARE_SIZE)
	) sprite_i (
		.clk_74a       (clk_74a),
		.reset_n       (reset_n),
		.frame_start   (frame_start),
		.key           (cont1_key),
		.square_rst    (square_rst),
		.square_load_x (square_load_x),
		.square_load_y (square_load_y),
		.square_new    (square_new),
		.square_x      (square_x),
		.square_y      (square_y)
	);

	pixel_shader #(
		.H_BPORCH    (H_BPORCH),
		.H_ACTIVE    (H_ACTIVE),
		.V_BPORCH    (V_BPORCH),
		.V_ACTIVE    (V_ACTIVE),
		.SQUARE_SIZE (SQUARE_SIZE)
	) shader_i (
		.clk_74a   (clk_74a),
		.reset_n   (reset_n),
		.x_count   (x_count),
		.y_count   (y_count),
		.square_x  (square_x),
		.square_y  (square_y),
		.key       (cont1_key),
		.chan_en   (chan_en),
		.video_rgb (video_rgb),
		.video_de  (video_de)
	);

endmodule

// ==== tb/test_pattern_tb.sv ====
// testbench for the test pattern core
// bridge registers, raster timing, pixel colours, d-pad motion, square
// control and frame counter on a reduced raster

module test_pattern_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import bridge_map_pkg::*;
	import video_pkg::*;

	// reduced raster for a short run
	localparam int H_BPORCH    = 2;
	localparam int H_ACTIVE    = 24;
	localparam int H_TOTAL     = 32;
	localparam int V_BPORCH    = 2;
	localparam int V_ACTIVE    = 16;
	localparam int V_TOTAL     = 20;
	localparam int SQUARE_SIZE = 4;

	localparam int CLK_PERIOD      = 40;
	localparam int FRAME_LEN       = H_TOTAL * V_TOTAL;
	localparam int WATCHDOG_FRAMES = 40;
	localparam int WATCHDOG_NS     = WATCHDOG_FRAMES * FRAME_LEN * CLK_PERIOD;
	// hs marks the output cycle of x = 3
	localparam int HS_X = 3;
	// square start and right clamp
	localparam int INIT_X = H_ACTIVE / 2 - SQUARE_SIZE / 2;
	localparam int INIT_Y = V_ACTIVE / 2 - SQUARE_SIZE / 2;
	localparam int MAX_X  = H_ACTIVE - SQUARE_SIZE;
	localparam int DPAD_FRAMES  = 11;
	localparam int PIXEL_FRAMES = 7;

	logic      clk_74a;
	logic      reset_n;
	bus_word_t bridge_addr;
	logic      bridge_wr;
	bus_word_t bridge_wr_data;
	logic      bridge_rd;
	bus_word_t bridge_rd_data;
	cont_key_t cont1_key;
	rgb_t      video_rgb;
	logic      video_de;
	logic      video_vs;
	logic      video_hs;

	// stimulus state seen by the checker
	integer     seed;
	string      test_name;
	logic       pix_check_en;
	int         exp_sq_x;
	int         exp_sq_y;
	cont_key_t  exp_keys;
	chan_mask_t exp_mask;
	int         bus_errors = 0;
	// checker state
	int         video_errors = 0;
	int         frames_checked = 0;
	int         pos;
	int         pix_x;
	int         pix_y;
	int         de_total;
	logic       vs_seen;
	logic       frame_chk;

	test_pattern_top #(
		.H_BPORCH    (H_BPORCH),
		.H_ACTIVE    (H_ACTIVE),
		.H_TOTAL     (H_TOTAL),
		.V_BPORCH    (V_BPORCH),
		.V_ACTIVE    (V_ACTIVE),
		.V_TOTAL     (V_TOTAL),
		.SQUARE_SIZE (SQUARE_SIZE)
	) dut_i (
		.clk_74a        (clk_74a),
		.reset_n        (reset_n),
		.bridge_addr    (bridge_addr),
		.bridge_wr      (bridge_wr),
		.bridge_wr_data (bridge_wr_data),
		.bridge_rd      (bridge_rd),
		.bridge_rd_data (bridge_rd_data),
		.cont1_key      (cont1_key),
		.video_rgb      (video_rgb),
		.video_de       (video_de),
		.video_vs       (video_vs),
		.video_hs       (video_hs)
	);

	initial begin
		clk_74a = 1'b0;
		forever #(CLK_PERIOD / 2) clk_74a = ~clk_74a;
	end

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	function automatic bit in_active(input int x, input int y);
		return (x >= H_BPORCH) && (x < H_BPORCH + H_ACTIVE) &&
		       (y >= V_BPORCH) && (y < V_BPORCH + V_ACTIVE);
	endfunction

	// colour for counter position (x,y)
	function automatic rgb_t expected_rgb(input int x, input int y, input int sq_x,
			input int sq_y, input cont_key_t keys, input chan_mask_t mask);
		int   vx;
		int   vy;
		rgb_t sq_rgb;
		vx = x - H_BPORCH;
		vy = y - V_BPORCH;
		if (!in_active(x, y)) return COLOR_BLACK;
		// edge markers before the square
		if (vx == 0) return COLOR_WHITE;
		if (vx == H_ACTIVE - 1) return COLOR_GREEN;
		if (vy == 0) return COLOR_RED;
		if (vy == V_ACTIVE - 1) return COLOR_BLUE;
		if (vx >= sq_x && vx < sq_x + SQUARE_SIZE && vy >= sq_y && vy < sq_y + SQUARE_SIZE) begin
			if (keys[KEY_FACE_A]) sq_rgb = COLOR_MAGENTA;
			else if (keys[KEY_FACE_B]) sq_rgb = COLOR_GREEN;
			else sq_rgb = COLOR_WHITE;
			// channel mask, red on bit 2
			if (!mask[2]) sq_rgb[23:16] = 8'h00;
			if (!mask[1]) sq_rgb[15:8] = 8'h00;
			if (!mask[0]) sq_rgb[7:0] = 8'h00;
			return sq_rgb;
		end
		return COLOR_BLACK;
	endfunction

	function automatic bit value_ok(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			return 1'b0;
		end
		return 1'b1;
	endfunction

	//////////////////////////////////////////////////
	// bridge and frame tasks
	//////////////////////////////////////////////////

	task automatic bridge_write(input bus_word_t addr, input bus_word_t data);
		@(posedge clk_74a);
		bridge_addr    <= addr;
		bridge_wr_data <= data;
		bridge_wr      <= 1'b1;
		@(posedge clk_74a);
		bridge_wr      <= 1'b0;
	endtask

	// read data is combinational, sampled mid cycle
	task automatic read_check(input string name, input bus_word_t addr,
			input bus_word_t expected);
		@(posedge clk_74a);
		bridge_addr <= addr;
		bridge_rd   <= 1'b1;
		@(negedge clk_74a);
		if (!value_ok(name, expected, bridge_rd_data)) bus_errors++;
		@(posedge clk_74a);
		bridge_rd   <= 1'b0;
	endtask

	// returns in the cycle of the vs pulse
	task automatic wait_vs();
		do begin
			@(negedge clk_74a);
		end while (video_vs !== 1'b1);
	endtask

	// one whole frame checked with these keys and mask
	task automatic show_frame(input string name, input cont_key_t keys,
			input chan_mask_t mask);
		test_name = name;
		exp_keys  = keys;
		exp_mask  = mask;
		@(posedge clk_74a);
		cont1_key <= keys;
		bridge_write(ADDR_CHAN_EN, bus_word_t'(mask));
		@(posedge clk_74a);
		pix_check_en <= 1'b1;
		wait_vs();
		@(posedge clk_74a);
		pix_check_en <= 1'b0;
		wait_vs();
	endtask

	//////////////////////////////////////////////////
	// raster and pixel checker
	//////////////////////////////////////////////////

	// cycle t after vs shows position t mod H_TOTAL, t div H_TOTAL
	always @(negedge clk_74a) begin
		if (!reset_n) begin
			vs_seen   = 1'b0;
			frame_chk = 1'b0;
		end else begin
			if (video_vs) begin
				if (vs_seen) begin
					if (!value_ok("vs_period", FRAME_LEN, pos + 1)) video_errors++;
					if (!value_ok("de_per_frame", H_ACTIVE * V_ACTIVE, de_total)) video_errors++;
				end
				vs_seen   = 1'b1;
				pos       = 0;
				de_total  = 0;
				frame_chk = pix_check_en;
				if (frame_chk) frames_checked++;
			end else if (vs_seen) begin
				pos = pos + 1;
			end
			if (vs_seen && pos >= FRAME_LEN) begin
				$display("vsync missing: no pulse within %0d cycles", FRAME_LEN);
				video_errors++;
				vs_seen = 1'b0;
			end else if (vs_seen) begin
				pix_x = pos % H_TOTAL;
				pix_y = pos / H_TOTAL;
				if (!value_ok("hsync", 32'(pix_x == HS_X), 32'(video_hs))) video_errors++;
				if (!value_ok("data_enable", 32'(in_active(pix_x, pix_y)), 32'(video_de)))
					video_errors++;
				if (video_de) de_total++;
				if (frame_chk) begin
					if (!value_ok($sformatf("%s (%0d,%0d)", test_name, pix_x, pix_y),
							32'(expected_rgb(pix_x, pix_y, exp_sq_x, exp_sq_y, exp_keys, exp_mask)),
							32'(video_rgb)))
						video_errors++;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin
		int        n;
		int        exp_x;
		int        exp_y;
		bus_word_t rand_word;
		seed           = 32'h4c3a;
		test_name      = "reset";
		pix_check_en   = 1'b0;
		exp_sq_x       = INIT_X;
		exp_sq_y       = INIT_Y;
		exp_keys       = '0;
		exp_mask       = 3'b111;
		reset_n        = 1'b0;
		bridge_addr    = '0;
		bridge_wr      = 1'b0;
		bridge_wr_data = '0;
		bridge_rd      = 1'b0;
		cont1_key      = '0;
		repeat (4) @(posedge clk_74a);
		reset_n <= 1'b1;

		// registers
		read_check("debug_reset", ADDR_DEBUG, 32'h1200_5678);
		read_check("anim_en_reset", ADDR_ANIM_EN, 32'h1);
		read_check("chan_en_reset", ADDR_CHAN_EN, 32'h7);
		repeat (4) begin
			rand_word = $random(seed);
			bridge_write(ADDR_SCRATCH, rand_word);
			read_check("scratch", ADDR_SCRATCH, rand_word);
		end
		bridge_write(ADDR_CHAN_EN, 32'hFFFF_FFF5);
		read_check("chan_en_width", ADDR_CHAN_EN, 32'h5);
		read_check("unmapped_low", 32'h0040_0000, 32'h0);
		read_check("unmapped_high", 32'hFFFF_FFFC, 32'h0);
		read_check("strobe_read", ADDR_FRAME_INCR, 32'h0);

		// pixels at the start position, face keys only
		show_frame("pixels_plain", 16'h0000, 3'b111);
		show_frame("pixels_face_a", 16'h0010, 3'b111);
		show_frame("pixels_face_b", 16'h0020, 3'b111);
		repeat (3) begin
			rand_word = $random(seed);
			show_frame("pixels_random_mask", {10'b0, rand_word[5:4], 4'b0}, rand_word[2:0]);
		end

		// up and right held, moves land on each frame start edge
		test_name = "dpad";
		wait_vs();
		@(posedge clk_74a);
		cont1_key <= 16'h0009;
		for (n = 1; n <= DPAD_FRAMES; n++) begin
			wait_vs();
			exp_x = (INIT_X + n > MAX_X) ? MAX_X : INIT_X + n;
			exp_y = (INIT_Y - n < 0) ? 0 : INIT_Y - n;
			read_check("dpad_right", ADDR_SQUARE_X, bus_word_t'(exp_x));
			read_check("dpad_up", ADDR_SQUARE_Y, bus_word_t'(exp_y));
		end
		@(posedge clk_74a);
		cont1_key <= '0;

		// load past the clamp, overlapping the edge markers
		bridge_write(ADDR_SQUARE_X, 32'd21);
		bridge_write(ADDR_SQUARE_Y, 32'd13);
		read_check("square_load_x", ADDR_SQUARE_X, 32'd21);
		read_check("square_load_y", ADDR_SQUARE_Y, 32'd13);
		exp_sq_x = 21;
		exp_sq_y = 13;
		show_frame("pixels_square_edge", 16'h0010, 3'b111);
		bridge_write(ADDR_SQUARE_RST, 32'h0);
		read_check("square_rst_x", ADDR_SQUARE_X, bus_word_t'(INIT_X));
		read_check("square_rst_y", ADDR_SQUARE_Y, bus_word_t'(INIT_Y));

		// frame counter
		wait_vs();
		bridge_write(ADDR_FRAME_RST, 32'h0);
		read_check("frame_rst", ADDR_FRAME_COUNT, 32'h0);
		for (n = 1; n <= 2; n++) begin
			wait_vs();
			read_check("frame_advance", ADDR_FRAME_COUNT, bus_word_t'(n));
		end
		bridge_write(ADDR_ANIM_EN, 32'h0);
		read_check("anim_en_clear", ADDR_ANIM_EN, 32'h0);
		repeat (2) wait_vs();
		read_check("frame_hold", ADDR_FRAME_COUNT, 32'h2);
		bridge_write(ADDR_FRAME_INCR, 32'h0);
		read_check("frame_incr", ADDR_FRAME_COUNT, 32'h3);
		bridge_write(ADDR_FRAME_RST, 32'h0);
		read_check("frame_rst_again", ADDR_FRAME_COUNT, 32'h0);

		if (!value_ok("frames_checked", PIXEL_FRAMES, frames_checked)) bus_errors++;
		$display("bus errors %0d, video errors %0d, frames checked %0d",
			bus_errors, video_errors, frames_checked);
		if (bus_errors == 0 && video_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// watchdog, 40 frames of cycles
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d frames", WATCHDOG_FRAMES);
		$display("bus errors %0d, video errors %0d, frames checked %0d",
			bus_errors, video_errors, frames_checked);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
design/bridge_map_pkg.sv
design/video_pkg.sv
design/bridge_regs.sv
design/raster_timing.sv
design/square_sprite.sv
design/pixel_shader.sv
design/test_pattern_top.sv
tb/test_pattern_tb.sv

// ==== Makefile ====
TOP       ?= test_pattern_tb
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0

FLIST := flist.f
SRCS  := $(shell grep -v '^+' $(FLIST))
SIM   := obj_dir/V$(TOP)

.PHONY: run clean
.DEFAULT_GOAL := run

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
